// ==== hdl/pdm_mic_defines.svh ====
`ifndef PDM_MIC_DEFINES_SVH
`define PDM_MIC_DEFINES_SVH

// Width of one filter output word.
`define PCM_WIDTH 32

// Width of one audio sample after saturation.
`define AUDIO_WIDTH 16

// Integrator and comb stage count of the CIC filter.
`define CIC_ORDER 4

// System clocks per half period of the microphone clock.
`define PDM_DIV 4

// Width of the decimation factor input.
`define DECIM_WIDTH 7

// Entries in the PCM FIFO, kept a power of two.
`define FIFO_DEPTH 8

`endif

// ==== hdl/pdm_mic_pkg.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

package pdm_mic_pkg;

    // One filter word. The reader looks at it as headroom bits sitting
    // above the audio sample, everybody else just moves the raw value.
    typedef union packed {
        logic [`PCM_WIDTH-1:0] raw;
        struct packed {
            logic [`PCM_WIDTH-`AUDIO_WIDTH-1:0] headroom;  // Must be zero for a clean sample.
            logic [`AUDIO_WIDTH-1:0]             audio;     // Sample as sent out.
        } split;
    } pcm_word_u;

endpackage : pdm_mic_pkg

`default_nettype wire

// ==== hdl/pdm_sampler.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module pdm_sampler (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic pdm_data_i,
    output logic pdm_clk_o,
    output logic pdm_bit_o,
    output logic pdm_valid_o
);

    localparam int CNT_W = ($clog2(`PDM_DIV) > 0) ? $clog2(`PDM_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             pdm_clk_q;
    logic             half_end;
    logic [1:0]       sync_q;
    logic             valid_q;

    //////////////////////////////
    // Microphone clock
    //////////////////////////////

    assign half_end = (div_cnt == CNT_W'(`PDM_DIV - 1));  // Last clock of a half period.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            div_cnt   <= '0;
            pdm_clk_q <= 1'b0;
        end else if (half_end) begin
            div_cnt   <= '0;
            pdm_clk_q <= ~pdm_clk_q;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Data capture
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        sync_q <= {sync_q[0], pdm_data_i};  // Two flops against metastability.
    end

    // The strobe lands on the first clock after the high phase has run out,
    // by then the synchronized bit has been stable for a clock or more.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pdm_clk_q & half_end;  // Once per microphone period.
        end
    end

    assign pdm_clk_o   = pdm_clk_q;
    assign pdm_bit_o   = sync_q[1];
    assign pdm_valid_o = valid_q;

    a_single_strobe : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pdm_valid_o |=> !pdm_valid_o
    );

endmodule : pdm_sampler

`default_nettype wire

// ==== hdl/cic_filter.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module cic_filter import pdm_mic_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clear_i,
    input  logic [`DECIM_WIDTH-1:0] decim_i,
    input  logic                    pdm_bit_i,
    input  logic                    pdm_valid_i,
    output pcm_word_u               pcm_o,
    output logic                    pcm_valid_o
);

    localparam int N = `CIC_ORDER;
    localparam int W = `PCM_WIDTH;

    //////////////////////////////
    // Decimation counter
    //////////////////////////////

    logic [`DECIM_WIDTH-1:0] decim_cnt;
    logic                    fire;

    // Fires on the R-th input strobe, so the counter runs 0 to R-1.
    assign fire = pdm_valid_i && (decim_cnt == decim_i - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            decim_cnt <= '0;
        end else if (fire) begin
            decim_cnt <= '0;                  // Start the next output period.
        end else if (pdm_valid_i) begin
            decim_cnt <= decim_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Integrators
    //////////////////////////////

    logic [W-1:0] integ_in [N];
    logic [W-1:0] integ_ff [N];

    for (genvar i = 0; i < N; i++) begin : g_integ
        if (i == 0) begin : g_head
            assign integ_in[i] = W'(pdm_bit_i);  // A one bit counts as +1.
        end else begin : g_tail
            assign integ_in[i] = integ_ff[i-1];  // Registered chain, one stage per clock.
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i || clear_i) begin
                integ_ff[i] <= '0;
            end else if (pdm_valid_i) begin
                integ_ff[i] <= integ_ff[i] + integ_in[i];  // Wraps, which the combs undo.
            end
        end
    end

    //////////////////////////////
    // Comb stages
    //////////////////////////////

    logic [W-1:0] comb_in  [N];
    logic [W-1:0] comb_dly [N];
    logic [W-1:0] comb_ff  [N];

    // Each stage subtracts its own input from one fire earlier (M = 1).
    // Stage 0 keeps the last integrator, the others the previous comb.
    for (genvar i = 0; i < N; i++) begin : g_comb
        if (i == 0) begin : g_head
            assign comb_in[i] = integ_ff[N-1];
        end else begin : g_tail
            assign comb_in[i] = comb_ff[i-1];
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i || clear_i) begin
                comb_dly[i] <= '0;
                comb_ff[i]  <= '0;
            end else if (fire) begin
                comb_dly[i] <= comb_in[i];                 // Delay of one output period.
                comb_ff[i]  <= comb_in[i] - comb_dly[i];
            end
        end
    end

    //////////////////////////////
    // Output
    //////////////////////////////

    logic [N-1:0] fill_q;

    // A one enters per fire, the top bit is set once N fires have passed.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            fill_q <= '0;
        end else if (fire) begin
            fill_q <= {fill_q[N-2:0], 1'b1};
        end
    end

    assign pcm_valid_o = fill_q[N-1] & fire & ~clear_i;
    assign pcm_o       = pcm_word_u'(comb_ff[N-1]);

    // A zero factor wraps the compare and would decimate by 128.
    a_decim_nonzero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !clear_i |-> (decim_i != '0)
    );

endmodule : cic_filter

`default_nettype wire

// ==== hdl/pcm_fifo.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module pcm_fifo import pdm_mic_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      clear_i,
    input  logic      wr_i,
    input  pcm_word_u wr_data_i,
    input  logic      rd_i,
    output pcm_word_u rd_data_o,
    output logic      empty_o,
    output logic      overflow_o
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    pcm_word_u   mem [`FIFO_DEPTH];
    pcm_word_u   rd_data_q;
    logic [AW:0] wr_ptr;       // Top bit tells a full buffer from an empty one.
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_ok;
    logic        overflow_q;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ok   = wr_i & ~full;  // A full buffer drops the word.

    //////////////////////////////
    // Pointers and flag
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            overflow_q <= 1'b0;
        end else if (wr_i && full) begin
            overflow_q <= 1'b1;  // Stays set until the next clear.
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rd_data_q <= mem[rd_ptr[AW-1:0]];  // Word shows up the clock after the pop.
        end
    end

    assign rd_data_o  = rd_data_q;
    assign overflow_o = overflow_q;

    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rd_i |-> !empty_o
    );

endmodule : pcm_fifo

`default_nettype wire

// ==== hdl/pcm_reader.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module pcm_reader import pdm_mic_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    rd_en_i,
    input  logic                    empty_i,
    input  pcm_word_u               word_i,
    output logic                    pop_o,
    output logic [`AUDIO_WIDTH-1:0] audio_o,
    output logic                    audio_valid_o,
    output logic                    clip_o
);

    logic                    pend_q;
    logic                    over;
    logic [`AUDIO_WIDTH-1:0] audio_q;
    logic                    valid_q;
    logic                    clip_q;

    // One word in flight at a time, the next pop waits for the read data.
    assign pop_o = rd_en_i & ~empty_i & ~pend_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= pop_o;  // FIFO data is valid while this is high.
        end
    end

    //////////////////////////////
    // Saturation
    //////////////////////////////

    assign over = (word_i.split.headroom != '0);  // Anything above 16 bits clips.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            clip_q  <= 1'b0;
        end else begin
            valid_q <= pend_q;
            if (pend_q) begin
                clip_q <= over;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pend_q) begin
            audio_q <= over ? '1 : word_i.split.audio;
        end
    end

    assign audio_o       = audio_q;
    assign audio_valid_o = valid_q;
    assign clip_o        = clip_q;

endmodule : pcm_reader

`default_nettype wire

// ==== hdl/pdm_mic_top.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module pdm_mic_top import pdm_mic_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clear_i,
    input  logic [`DECIM_WIDTH-1:0] decim_i,
    input  logic                    pdm_data_i,
    input  logic                    rd_en_i,
    output logic                    pdm_clk_o,
    output logic [`AUDIO_WIDTH-1:0] audio_o,
    output logic                    audio_valid_o,
    output logic                    clip_o,
    output logic                    overflow_o
);

    logic      pdm_bit;     // Synchronized microphone bit.
    logic      pdm_valid;
    pcm_word_u pcm_word;    // Filter output, before buffering.
    logic      pcm_valid;
    pcm_word_u fifo_word;
    logic      fifo_empty;
    logic      fifo_pop;

    pdm_sampler pdm_sampler_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pdm_data_i  (pdm_data_i),
        .pdm_clk_o   (pdm_clk_o),
        .pdm_bit_o   (pdm_bit),
        .pdm_valid_o (pdm_valid)
    );

    cic_filter cic_filter_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear_i),
        .decim_i     (decim_i),
        .pdm_bit_i   (pdm_bit),
        .pdm_valid_i (pdm_valid),
        .pcm_o       (pcm_word),
        .pcm_valid_o (pcm_valid)
    );

    pcm_fifo pcm_fifo_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (clear_i),
        .wr_i       (pcm_valid),
        .wr_data_i  (pcm_word),
        .rd_i       (fifo_pop),
        .rd_data_o  (fifo_word),
        .empty_o    (fifo_empty),
        .overflow_o (overflow_o)
    );

    pcm_reader pcm_reader_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rd_en_i       (rd_en_i),
        .empty_i       (fifo_empty),
        .word_i        (fifo_word),
        .pop_o         (fifo_pop),
        .audio_o       (audio_o),
        .audio_valid_o (audio_valid_o),
        .clip_o        (clip_o)
    );

endmodule : pdm_mic_top

`default_nettype wire

// ==== bench/pdm_mic_tb.sv ====
`default_nettype none

`include "pdm_mic_defines.svh"

module pdm_mic_tb import pdm_mic_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 5;
    localparam int CHECKS     = 4;   // Steady outputs compared per row.
    localparam int MAX_DECIM  = 64;

    // Stimulus table. Row 1 is the one that also exercises back-pressure.
    localparam logic [`DECIM_WIDTH-1:0] ROW_DECIM [NUM_ROWS] = '{
        `DECIM_WIDTH'(16), `DECIM_WIDTH'(16), `DECIM_WIDTH'(16), `DECIM_WIDTH'(8),
        `DECIM_WIDTH'(16)};
    localparam logic [7:0] ROW_PATTERN [NUM_ROWS] = '{8'hFF, 8'hAA, 8'h88, 8'hFF, 8'h00};
    localparam int         ROW_SKIP    [NUM_ROWS] = '{8, 8, 8, 8, 8};
    localparam logic [`AUDIO_WIDTH-1:0] ROW_AUDIO [NUM_ROWS] = '{
        16'hFFFF, 16'h8000, 16'h4000, 16'h1000, 16'h0000};
    localparam logic ROW_CLIP [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    localparam logic ROW_GAPS [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    clear_i;
    logic [`DECIM_WIDTH-1:0] decim_i;
    logic                    pdm_data_i;
    logic                    rd_en_i;
    logic                    pdm_clk_o;
    logic [`AUDIO_WIDTH-1:0] audio_o;
    logic                    audio_valid_o;
    logic                    clip_o;
    logic                    overflow_o;

    logic [7:0]  cur_pattern;
    logic [2:0]  bit_idx;
    integer      seed;
    pcm_word_u   sample_q [$];       // Samples seen on the output, clip kept in the headroom.
    pcm_word_u   mon_word;
    logic        valid_prev;
    logic [1:0]  rd_hist;

    pdm_mic_top pdm_mic_top_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .clear_i       (clear_i),
        .decim_i       (decim_i),
        .pdm_data_i    (pdm_data_i),
        .rd_en_i       (rd_en_i),
        .pdm_clk_o     (pdm_clk_o),
        .audio_o       (audio_o),
        .audio_valid_o (audio_valid_o),
        .clip_o        (clip_o),
        .overflow_o    (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_audio(input string name, input logic [`AUDIO_WIDTH-1:0] got,
                               input logic [`AUDIO_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run("Audio sample mismatch.");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_run("Flag mismatch.");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run("Count mismatch.");
        end
    endtask

    //////////////////////////////
    // PDM driver and monitor
    //////////////////////////////

    // A new bit goes out one clock after each rising microphone clock edge.
    initial begin
        bit_idx     = '0;
        cur_pattern = 8'h00;
        pdm_data_i  = 1'b0;
        forever begin
            @(posedge pdm_clk_o);
            @(posedge clk_i);
            pdm_data_i <= cur_pattern[bit_idx];
            bit_idx = bit_idx + 1'b1;  // Rotates through the 8-bit pattern.
        end
    end

    // A sample must follow a pop, which needs rd_en_i two cycles earlier.
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            valid_prev = 1'b0;
            rd_hist    = 2'b00;
        end else begin
            if (audio_valid_o) begin
                if (valid_prev) begin
                    stop_run("audio_valid_o stayed high for more than one cycle.");
                end
                if (!rd_hist[1]) begin
                    stop_run("A sample appeared while rd_en_i was low.");
                end
                mon_word.split.headroom = {{(`PCM_WIDTH-`AUDIO_WIDTH-1){1'b0}}, clip_o};
                mon_word.split.audio    = audio_o;
                sample_q.push_back(mon_word);
            end
            valid_prev = audio_valid_o;
            rd_hist    = {rd_hist[0], rd_en_i};
        end
    end

    //////////////////////////////
    // Sequences
    //////////////////////////////

    task automatic get_sample(output logic [`AUDIO_WIDTH-1:0] audio, output logic clip);
        pcm_word_u word;
        while (sample_q.size() == 0) begin
            @(negedge clk_i);
        end
        word  = sample_q.pop_front();
        audio = word.split.audio;
        clip  = word.split.headroom[0];
    endtask

    task automatic measure_pdm_period(output int clocks);
        logic prev;
        logic seen;
        int   n;
        @(negedge clk_i);
        prev = pdm_clk_o;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk_i);
            seen = !prev && pdm_clk_o;
            prev = pdm_clk_o;
        end
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk_i);
            n    = n + 1;
            seen = !prev && pdm_clk_o;
            prev = pdm_clk_o;
        end
        clocks = n;
    endtask

    task automatic start_row(input int r);
        @(posedge clk_i);
        rd_en_i <= 1'b0;
        repeat (4) @(posedge clk_i);  // Lets a sample in flight land.
        clear_i <= 1'b1;
        @(posedge clk_i);
        decim_i <= ROW_DECIM[r];
        cur_pattern = ROW_PATTERN[r];
        repeat (2) @(posedge clk_i);
        clear_i <= 1'b0;
        @(negedge clk_i);
        check_flag("overflow_o", overflow_o, 1'b0);
        sample_q.delete();
        @(posedge clk_i);
        rd_en_i <= 1'b1;
    endtask

    task automatic apply_gap(input int r);
        int gap;
        gap = ($random(seed) & 32'h7fff_ffff) % (2 * int'(ROW_DECIM[r]) * 2 * `PDM_DIV);
        if (gap > 0) begin
            @(posedge clk_i);
            rd_en_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
            rd_en_i <= 1'b1;
        end
    endtask

    // Starts half an output period off the filter's fire, so the drain
    // of the full FIFO never meets a new word.
    task automatic run_backpressure(input int r);
        int                      hold;
        logic [`AUDIO_WIDTH-1:0] audio;
        logic                    clip;
        hold = (`FIFO_DEPTH + 2) * int'(ROW_DECIM[r]) * 2 * `PDM_DIV
             + int'(ROW_DECIM[r]) * `PDM_DIV;
        @(posedge clk_i);
        rd_en_i <= 1'b0;
        sample_q.delete();
        repeat (hold) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("overflow_o", overflow_o, 1'b1);
        @(posedge clk_i);
        rd_en_i <= 1'b1;
        repeat (4 * `FIFO_DEPTH) @(posedge clk_i);
        @(negedge clk_i);
        check_count("samples after overflow", sample_q.size(), `FIFO_DEPTH);
        repeat (`FIFO_DEPTH) begin
            get_sample(audio, clip);
            check_audio("audio_o", audio, ROW_AUDIO[r]);
            check_flag("clip_o", clip, ROW_CLIP[r]);
        end
        check_flag("overflow_o", overflow_o, 1'b1);  // Held until the next clear.
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic [`AUDIO_WIDTH-1:0] audio;
        logic                    clip;
        int                      period;
        seed    = 50936;
        rst_n_i = 1'b0;
        clear_i = 1'b0;
        decim_i = ROW_DECIM[0];
        rd_en_i = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("audio_valid_o", audio_valid_o, 1'b0);
        check_flag("clip_o", clip_o, 1'b0);
        check_flag("overflow_o", overflow_o, 1'b0);
        measure_pdm_period(period);
        check_count("pdm_clk_o period", period, 2 * `PDM_DIV);

        for (int r = 0; r < NUM_ROWS; r++) begin
            start_row(r);
            repeat (ROW_SKIP[r]) get_sample(audio, clip);  // Filter still settling.
            for (int k = 0; k < CHECKS; k++) begin
                if (ROW_GAPS[r]) begin
                    apply_gap(r);
                end
                get_sample(audio, clip);
                check_audio("audio_o", audio, ROW_AUDIO[r]);
                check_flag("clip_o", clip, ROW_CLIP[r]);
            end
            if (ROW_GAPS[r]) begin
                @(negedge clk_i);
                check_flag("overflow_o", overflow_o, 1'b0);
            end else begin
                run_backpressure(r);
            end
        end

        $display("Regression passed");
        $finish;
    end

    // Worst case per row at the largest decimation factor, doubled.
    initial begin
        longint limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + longint'(ROW_SKIP[r] + CHECKS + `FIFO_DEPTH + 4)
                  * MAX_DECIM * 2 * `PDM_DIV * CLK_PERIOD;
        end
        limit = limit * 2;
        #(limit);
        stop_run("Watchdog timeout, the test sequence did not finish in time.");
    end

endmodule : pdm_mic_tb

`default_nettype wire

// ==== pdm_mic.f ====
+incdir+hdl
hdl/pdm_mic_pkg.sv
hdl/pdm_sampler.sv
hdl/cic_filter.sv
hdl/pcm_fifo.sv
hdl/pcm_reader.sv
hdl/pdm_mic_top.sv
bench/pdm_mic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PDM microphone front end with Verilator and run the regression.
# The simulator exits with a failing status on $fatal, so set -e ends the script there.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f pdm_mic.f \
    --top-module pdm_mic_tb \
    -o pdm_mic_sim

./obj_dir/pdm_mic_sim
